// ==== hw/dct_macros.svh ====
// Global widths of the 1D DCT datapath
// Pack length and lane count are tied to the 8-point butterfly and must stay 8 and 4

`ifndef DCT_MACROS_SVH
`define DCT_MACROS_SVH

// Unsigned input pixel
`define DCT_PX_WIDTH 8

// Fraction bits of a DCT coefficient
`define DCT_COEF_FRACT_WIDTH 11

// Pixels per pack and multiplier lanes
`define DCT_PACK_LEN 8
`define DCT_LANES 4

// Multiplier operand, sign included
`define DCT_MULT_WIDTH (`DCT_PX_WIDTH + 2 + `DCT_COEF_FRACT_WIDTH)

// Adder tree result after two levels
`define DCT_OUT_WIDTH (`DCT_MULT_WIDTH + 2)

// Output data rounded up to whole bytes
`define DCT_TDATA_WIDTH ((((`DCT_OUT_WIDTH) + 7) / 8) * 8)

`endif

// ==== hw/dct_stream_pkg.sv ====
// Beat and pack types at the stream side of the DCT engine
// Output data is a signed fixed-point value with DCT_COEF_FRACT_WIDTH fraction bits

`include "dct_macros.svh"

package dct_stream_pkg;

  // One input pixel beat, last marks line end and user marks frame start
  typedef struct packed {
    logic [`DCT_PX_WIDTH-1:0] data;
    logic                     last;
    logic                     user;
  } video_beat_t;

  // One output coefficient beat
  typedef struct packed {
    logic signed [`DCT_TDATA_WIDTH-1:0] data;
    logic                               last;
    logic                               user;
  } dct_beat_t;

  // Pixel after subtracting half the pixel range
  typedef logic signed [`DCT_PX_WIDTH:0] shifted_px_t;
  typedef shifted_px_t [`DCT_PACK_LEN-1:0] pack_px_t;

  // Eight pixels in arrival order, index 0 first, with pack flags
  typedef struct packed {
    pack_px_t px;
    logic     last;
    logic     user;
  } pixel_pack_t;

endpackage

// ==== hw/dct_math_pkg.sv ====
// Arithmetic types, coefficient table and sign-magnitude helpers
// Coefficients are 0.5*cos(k*pi/16) scaled by 2^DCT_COEF_FRACT_WIDTH

`include "dct_macros.svh"

package dct_math_pkg;

  typedef logic signed [`DCT_PX_WIDTH+1:0] pair_t;
  typedef logic [`DCT_PX_WIDTH+1:0] pair_sm_t;
  typedef logic signed [`DCT_COEF_FRACT_WIDTH:0] coef_t;
  typedef logic signed [`DCT_MULT_WIDTH-1:0] lane_product_t;
  typedef logic [`DCT_MULT_WIDTH-1:0] product_sm_t;

  typedef struct packed {
    pair_t [`DCT_LANES-1:0] sum;
    pair_t [`DCT_LANES-1:0] diff;
    logic                   last;
    logic                   user;
  } butterfly_t;

  typedef struct packed {
    logic       run;
    logic [2:0] row;
    logic       first;
    logic       last;
  } row_ctl_t;

  // Even rows act on mirrored sums, odd rows on mirrored differences
  // c1..c7 are 1004 946 851 724 569 392 200
  localparam coef_t DCT_COEFS [`DCT_PACK_LEN][`DCT_LANES] = '{
    '{ 724,   724,   724,   724},
    '{1004,   851,   569,   200},
    '{ 946,   392,  -392,  -946},
    '{ 851,  -200, -1004,  -569},
    '{ 724,  -724,  -724,   724},
    '{ 569, -1004,   200,   851},
    '{ 392,  -946,   946,  -392},
    '{ 200,  -569,   851, -1004}
  };

  function automatic pair_sm_t to_sign_mag(input pair_t value);
    pair_sm_t result;
    result = value;
    if (value[`DCT_PX_WIDTH+1])
    begin
      result[`DCT_PX_WIDTH:0] = ~value[`DCT_PX_WIDTH:0] + 1'b1;
    end
    return result;
  endfunction

  // Negative zero from the multiplier folds to plain zero
  function automatic lane_product_t to_twos(input product_sm_t value);
    lane_product_t result;
    result = {1'b0, value[`DCT_MULT_WIDTH-2:0]};
    if (value[`DCT_MULT_WIDTH-1] && (|value[`DCT_MULT_WIDTH-2:0]))
    begin
      result[`DCT_MULT_WIDTH-1]   = 1'b1;
      result[`DCT_MULT_WIDTH-2:0] = ~value[`DCT_MULT_WIDTH-2:0] + 1'b1;
    end
    return result;
  endfunction

endpackage

// ==== hw/dct_pack_buffer.sv ====
// Two-slot ping-pong buffer collecting level-shifted pixels into packs of 8
// Line length must be a multiple of DCT_PACK_LEN, which must be a power of two

`timescale 1ns/1ps

`include "dct_macros.svh"

module dct_pack_buffer
  import dct_stream_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  video_beat_t video_i,
  input  logic        video_valid_i,
  output logic        video_ready_o,
  input  logic        pack_take_i,
  output pixel_pack_t pack_o,
  output logic        pack_valid_o
);

  localparam int CNT_WIDTH = $clog2(`DCT_PACK_LEN);
  localparam shifted_px_t HALF_RANGE = (`DCT_PX_WIDTH + 1)'(2 ** (`DCT_PX_WIDTH - 1));

  pack_px_t               slot_px [2];
  logic [1:0]             full;
  logic [1:0]             slot_last;
  logic [1:0]             slot_user;
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [CNT_WIDTH-1:0]   px_cnt;
  logic                   accept;
  logic                   pack_done;
  shifted_px_t            px_shifted;

  // A slot being written is never full, so it cannot be the one read
  assign video_ready_o = !full[wr_ptr];
  assign accept        = video_valid_i && video_ready_o;
  assign pack_done     = accept && (px_cnt == CNT_WIDTH'(`DCT_PACK_LEN - 1));
  assign px_shifted    = {1'b0, video_i.data} - HALF_RANGE;

  // New pixel enters at the top, so the first one ends at index 0
  always_ff @(posedge clk_i)
    if (accept)
      slot_px[wr_ptr] <= {px_shifted, slot_px[wr_ptr][`DCT_PACK_LEN-1:1]};

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      px_cnt    <= '0;
      full      <= 2'b00;
      slot_last <= 2'b00;
      slot_user <= 2'b00;
    end
    else
    begin
      if (accept)
        px_cnt <= px_cnt + 1'b1;
      if (pack_done)
        wr_ptr <= !wr_ptr;
      if (pack_take_i)
      begin
        rd_ptr            <= !rd_ptr;
        full[rd_ptr]      <= 1'b0;
        slot_last[rd_ptr] <= 1'b0;
        slot_user[rd_ptr] <= 1'b0;
      end
      if (pack_done)
        full[wr_ptr] <= 1'b1;
      // Flags of the whole pack collect any beat that carried them
      if (accept && video_i.last)
        slot_last[wr_ptr] <= 1'b1;
      if (accept && video_i.user)
        slot_user[wr_ptr] <= 1'b1;
    end

  assign pack_valid_o = full[rd_ptr];
  assign pack_o.px    = slot_px[rd_ptr];
  assign pack_o.last  = slot_last[rd_ptr];
  assign pack_o.user  = slot_user[rd_ptr];

endmodule

// ==== hw/dct_butterfly.sv ====
// Mirrored sums and differences of one pack, registered on take
// Pairs are pixel j with pixel 7-j, sign-extended by one bit first

`timescale 1ns/1ps

`include "dct_macros.svh"

module dct_butterfly
  import dct_stream_pkg::*;
  import dct_math_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  pixel_pack_t pack_i,
  input  logic        load_i,
  output butterfly_t  bfly_o
);

  pair_t                  px_ext [`DCT_PACK_LEN];
  pair_t [`DCT_LANES-1:0] sum_q;
  pair_t [`DCT_LANES-1:0] diff_q;
  logic                   last_q;
  logic                   user_q;

  always_comb
    for (int i = 0; i < `DCT_PACK_LEN; i++)
      px_ext[i] = {pack_i.px[i][`DCT_PX_WIDTH], pack_i.px[i]};

  always_ff @(posedge clk_i)
    if (load_i)
      for (int j = 0; j < `DCT_LANES; j++)
      begin
        sum_q[j]  <= px_ext[j] + px_ext[`DCT_PACK_LEN-1-j];
        diff_q[j] <= px_ext[j] - px_ext[`DCT_PACK_LEN-1-j];
      end

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      last_q <= 1'b0;
      user_q <= 1'b0;
    end
    else if (load_i)
    begin
      last_q <= pack_i.last;
      user_q <= pack_i.user;
    end

  assign bfly_o.sum  = sum_q;
  assign bfly_o.diff = diff_q;
  assign bfly_o.last = last_q;
  assign bfly_o.user = user_q;

endmodule

// ==== hw/dct_row_sequencer.sv ====
// Steps through output rows F0 to F7 of the pack held in the butterfly
// A new pack is taken while idle or on the last row of a running pack

`timescale 1ns/1ps

`include "dct_macros.svh"

module dct_row_sequencer
  import dct_math_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       pack_valid_i,
  input  logic       advance_i,
  // Bit 1 is the pack's last flag, bit 0 its user flag
  input  logic [1:0] flags_i,
  output logic       pack_take_o,
  output row_ctl_t   row_o
);

  localparam logic [2:0] LAST_ROW = 3'(`DCT_PACK_LEN - 1);

  logic       run_q;
  logic [2:0] row_q;
  logic       row_end;

  assign row_end     = run_q && (row_q == LAST_ROW) && advance_i;
  assign pack_take_o = pack_valid_i && (!run_q || row_end);

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      run_q <= 1'b0;
    else if (pack_take_o)
      run_q <= 1'b1;
    else if (row_end)
      run_q <= 1'b0;

  // Wraps back to row 0 after row 7, ready for the next pack
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      row_q <= 3'd0;
    else if (run_q && advance_i)
      row_q <= row_q + 1'b1;

  assign row_o.run   = run_q;
  assign row_o.row   = row_q;
  // User goes with F0, last goes with F7
  assign row_o.first = run_q && (row_q == 3'd0) && flags_i[0];
  assign row_o.last  = run_q && (row_q == LAST_ROW) && flags_i[1];

endmodule

// ==== hw/dct_mult_lane.sv ====
// One multiplier lane, serving column LANE of the coefficient table
// Multiplies in sign-magnitude and returns a two's complement product

`timescale 1ns/1ps

`include "dct_macros.svh"

module dct_mult_lane
  import dct_math_pkg::*;
#(
  parameter int LANE = 0
)(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          advance_i,
  input  row_ctl_t      row_i,
  input  pair_t         sum_i,
  input  pair_t         diff_i,
  output lane_product_t product_o
);

  localparam int MAG_WIDTH  = `DCT_MULT_WIDTH - 1;
  localparam int PROD_WIDTH = 2 * MAG_WIDTH;

  pair_sm_t                         operand_sm;
  coef_t                            coef;
  logic [`DCT_COEF_FRACT_WIDTH-1:0] coef_mag;
  logic [`DCT_MULT_WIDTH-1:0]       op_q;
  logic [`DCT_MULT_WIDTH-1:0]       coef_q;
  logic [PROD_WIDTH-1:0]            prod_mag_q;
  logic                             prod_sign_q;

  // Odd rows use the differences
  assign operand_sm = to_sign_mag(row_i.row[0] ? diff_i : sum_i);
  assign coef       = DCT_COEFS[row_i.row][LANE];
  assign coef_mag   = coef[`DCT_COEF_FRACT_WIDTH] ? `DCT_COEF_FRACT_WIDTH'(-coef) :
                                                    coef[`DCT_COEF_FRACT_WIDTH-1:0];

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      op_q        <= '0;
      coef_q      <= '0;
      prod_mag_q  <= '0;
      prod_sign_q <= 1'b0;
    end
    else if (advance_i)
    begin
      // Operand magnitude is placed above the fraction bits
      op_q        <= {operand_sm, `DCT_COEF_FRACT_WIDTH'(0)};
      coef_q      <= {coef[`DCT_COEF_FRACT_WIDTH], (`DCT_PX_WIDTH + 1)'(0), coef_mag};
      prod_mag_q  <= op_q[MAG_WIDTH-1:0] * coef_q[MAG_WIDTH-1:0];
      prod_sign_q <= op_q[`DCT_MULT_WIDTH-1] ^ coef_q[`DCT_MULT_WIDTH-1];
    end

  // Middle slice keeps the integer part of the pair and all fraction bits
  // The upper bits are always zero for pixel-range operands
  assign product_o = to_twos({prod_sign_q,
                              prod_mag_q[PROD_WIDTH-`DCT_PX_WIDTH-2:`DCT_COEF_FRACT_WIDTH]});

endmodule

// ==== hw/dct_output_stage.sv ====
// Two-level adder tree, output register and pipeline-advance control
// The whole pipeline stalls while the output holds a beat that is not read

`timescale 1ns/1ps

`include "dct_macros.svh"

module dct_output_stage
  import dct_math_pkg::*;
  import dct_stream_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  row_ctl_t                       row_i,
  input  lane_product_t [`DCT_LANES-1:0] products_i,
  input  logic                           dct_ready_i,
  output logic                           advance_o,
  output dct_beat_t                      dct_o,
  output logic                           dct_valid_o
);

  localparam int SUM_WIDTH  = `DCT_MULT_WIDTH + 1;
  localparam int PIPE_DEPTH = 4;

  logic [1:0][SUM_WIDTH-1:0]  add_q;
  logic [`DCT_OUT_WIDTH-1:0]  dct_q;
  logic [PIPE_DEPTH-1:0]      valid_pipe;
  logic [PIPE_DEPTH-1:0]      first_pipe;
  logic [PIPE_DEPTH-1:0]      last_pipe;

  assign advance_o = !dct_valid_o || dct_ready_i;

  always_ff @(posedge clk_i)
    if (advance_o)
    begin
      add_q[0] <= {products_i[0][`DCT_MULT_WIDTH-1], products_i[0]} +
                  {products_i[1][`DCT_MULT_WIDTH-1], products_i[1]};
      add_q[1] <= {products_i[2][`DCT_MULT_WIDTH-1], products_i[2]} +
                  {products_i[3][`DCT_MULT_WIDTH-1], products_i[3]};
      dct_q    <= {add_q[0][SUM_WIDTH-1], add_q[0]} +
                  {add_q[1][SUM_WIDTH-1], add_q[1]};
    end

  // Row control crosses two lane stages and two adder stages
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      valid_pipe <= '0;
      first_pipe <= '0;
      last_pipe  <= '0;
    end
    else if (advance_o)
    begin
      valid_pipe <= {valid_pipe[PIPE_DEPTH-2:0], row_i.run};
      first_pipe <= {first_pipe[PIPE_DEPTH-2:0], row_i.first};
      last_pipe  <= {last_pipe[PIPE_DEPTH-2:0], row_i.last};
    end

  assign dct_o.data  = `DCT_TDATA_WIDTH'($signed(dct_q));
  assign dct_o.last  = last_pipe[PIPE_DEPTH-1];
  assign dct_o.user  = first_pipe[PIPE_DEPTH-1];
  assign dct_valid_o = valid_pipe[PIPE_DEPTH-1];

endmodule

// ==== hw/dct_1d_top.sv ====
// 1D 8-point DCT on an unsigned pixel stream, one coefficient per beat
// Lines must be a multiple of 8 pixels; output order is F0 to F7 per pack

`timescale 1ns/1ps

`include "dct_macros.svh"

module dct_1d_top
  import dct_stream_pkg::*;
  import dct_math_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  video_beat_t video_i,
  input  logic        video_valid_i,
  output logic        video_ready_o,
  output dct_beat_t   dct_o,
  output logic        dct_valid_o,
  input  logic        dct_ready_i
);

  pixel_pack_t                    pack;
  logic                           pack_valid;
  logic                           pack_take;
  butterfly_t                     bfly;
  row_ctl_t                       row;
  logic                           advance;
  lane_product_t [`DCT_LANES-1:0] products;

  dct_pack_buffer u_pack_buffer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .video_i       (video_i),
    .video_valid_i (video_valid_i),
    .video_ready_o (video_ready_o),
    .pack_take_i   (pack_take),
    .pack_o        (pack),
    .pack_valid_o  (pack_valid)
  );

  dct_butterfly u_butterfly (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .pack_i (pack),
    .load_i (pack_take),
    .bfly_o (bfly)
  );

  dct_row_sequencer u_row_sequencer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pack_valid_i (pack_valid),
    .advance_i    (advance),
    .flags_i      ({bfly.last, bfly.user}),
    .pack_take_o  (pack_take),
    .row_o        (row)
  );

  for (genvar g = 0; g < `DCT_LANES; g++)
  begin : g_lane
    dct_mult_lane #(
      .LANE (g)
    ) u_mult_lane (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .advance_i (advance),
      .row_i     (row),
      .sum_i     (bfly.sum[g]),
      .diff_i    (bfly.diff[g]),
      .product_o (products[g])
    );
  end

  dct_output_stage u_output_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .row_i       (row),
    .products_i  (products),
    .dct_ready_i (dct_ready_i),
    .advance_o   (advance),
    .dct_o       (dct_o),
    .dct_valid_o (dct_valid_o)
  );

endmodule

// ==== dv/dct_ref_model.svh ====
// Expected coefficients of one pack, computed from the cosine definition
// Results are exact integers with DCT_COEF_FRACT_WIDTH fraction bits

`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

localparam real REF_PI = 3.14159265358979323846;

// Entry r, j is 0.5*cos((2j+1)*r*pi/16); F0 uses c4 in every column
function automatic int cos_coef(input int r, input int j);
  real scaled;
  if (r == 0)
    scaled = 0.5 * $cos(REF_PI / 4.0);
  else
    scaled = 0.5 * $cos((2 * j + 1) * r * REF_PI / (2.0 * `DCT_PACK_LEN));
  scaled = scaled * (1 << `DCT_COEF_FRACT_WIDTH);
  if (scaled < 0.0)
    return -$rtoi(0.5 - scaled);
  else
    return $rtoi(scaled + 0.5);
endfunction

// Pixel i of the pack sits at bits [i*W +: W], first arrival at index 0
function automatic int expected_coef(input logic [`DCT_PACK_LEN*`DCT_PX_WIDTH-1:0] pixels,
                                     input int r);
  int shifted [`DCT_PACK_LEN];
  int pair;
  int acc;
  for (int i = 0; i < `DCT_PACK_LEN; i++)
    shifted[i] = int'(pixels[i*`DCT_PX_WIDTH +: `DCT_PX_WIDTH]) - (1 << (`DCT_PX_WIDTH - 1));
  acc = 0;
  for (int j = 0; j < `DCT_PACK_LEN / 2; j++)
  begin
    // Even rows take mirrored sums, odd rows mirrored differences
    if (r % 2 == 0)
      pair = shifted[j] + shifted[`DCT_PACK_LEN-1-j];
    else
      pair = shifted[j] - shifted[`DCT_PACK_LEN-1-j];
    acc += cos_coef(r, j) * pair;
  end
  return acc;
endfunction

`endif

// ==== dv/dct_1d_tb.sv ====
// Testbench for the 1D DCT engine that checks every beat against a cosine model
// Stops at the first mismatch; a watchdog bounds the run

`timescale 1ns/1ps

`include "dct_macros.svh"

module dct_1d_tb
  import dct_stream_pkg::*;
();

  localparam int DIRECTED_PACKS  = 3;
  localparam int FAST_PACKS      = 40;
  localparam int BP_PACKS        = 40;
  localparam int HOLD_PACKS      = 6;
  localparam int TOTAL_PACKS     = DIRECTED_PACKS + FAST_PACKS + BP_PACKS + HOLD_PACKS;
  localparam int WATCHDOG_CYCLES = 40 * TOTAL_PACKS + 1000;
  localparam int DRAIN_CYCLES    = 500;
  localparam int STALL_CYCLES    = 40 * HOLD_PACKS;
  localparam int PACK_BITS       = `DCT_PACK_LEN * `DCT_PX_WIDTH;
  localparam int READY_HIGH      = 0;
  localparam int READY_RANDOM    = 1;
  localparam int READY_LOW       = 2;

  logic        clk;
  logic        rst;
  video_beat_t video_beat;
  logic        video_valid;
  logic        video_ready;
  dct_beat_t   dct_beat;
  logic        dct_valid;
  logic        dct_ready;

  integer      seed;
  int          ready_mode;
  dct_beat_t   exp_q [$];
  dct_beat_t   expected;
  dct_beat_t   held_beat;
  logic        hold_pending;
  int          out_count;

  // Data of the most recent pack, indexed by coefficient
  logic signed [`DCT_TDATA_WIDTH-1:0] got_data [`DCT_PACK_LEN];

  `include "dct_ref_model.svh"

  dct_1d_top u_dct_1d_top (
    .clk_i         (clk),
    .rst_i         (rst),
    .video_i       (video_beat),
    .video_valid_i (video_valid),
    .video_ready_o (video_ready),
    .dct_o         (dct_beat),
    .dct_valid_o   (dct_valid),
    .dct_ready_i   (dct_ready)
  );

  always #5 clk = !clk;

  task automatic report_error(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  // Output ready pattern changes on the falling edge
  always @(negedge clk)
  begin
    if (ready_mode == READY_RANDOM)
      dct_ready = ($random(seed) & 3) != 0;
    else
      dct_ready = (ready_mode == READY_HIGH);
  end

  // Starts and ends on a falling edge and sometimes idles one cycle first
  task automatic drive_beat(input logic [`DCT_PX_WIDTH-1:0] px, input logic last,
                            input logic user);
    if (($random(seed) & 3) == 0)
    begin
      video_valid = 1'b0;
      @(negedge clk);
    end
    video_beat.data = px;
    video_beat.last = last;
    video_beat.user = user;
    video_valid     = 1'b1;
    @(posedge clk);
    while (!video_ready)
      @(posedge clk);
    @(negedge clk);
    video_valid = 1'b0;
  endtask

  // A position of -1 means no beat of the pack carries that flag
  task automatic transmit_pack(input logic [PACK_BITS-1:0] pixels, input int user_pos,
                               input int last_pos);
    dct_beat_t beat;
    for (int i = 0; i < `DCT_PACK_LEN; i++)
      drive_beat(pixels[i*`DCT_PX_WIDTH +: `DCT_PX_WIDTH], i == last_pos, i == user_pos);
    for (int r = 0; r < `DCT_PACK_LEN; r++)
    begin
      beat.data = `DCT_TDATA_WIDTH'(expected_coef(pixels, r));
      beat.user = (r == 0) && (user_pos >= 0);
      beat.last = (r == `DCT_PACK_LEN - 1) && (last_pos >= 0);
      exp_q.push_back(beat);
    end
  endtask

  task automatic random_pack();
    logic [PACK_BITS-1:0] pixels;
    int                   user_pos;
    int                   last_pos;
    pixels   = {$random(seed), $random(seed)};
    user_pos = (($random(seed) & 3) == 0) ? ($random(seed) & 7) : -1;
    last_pos = (($random(seed) & 3) == 0) ? ($random(seed) & 7) : -1;
    transmit_pack(pixels, user_pos, last_pos);
  endtask

  // Ends on a falling edge; extra cycles after the queue empties catch surplus beats
  task automatic drain_queue();
    int wait_cycles;
    wait_cycles = 0;
    while ((exp_q.size() != 0) && (wait_cycles < DRAIN_CYCLES))
    begin
      wait_cycles++;
      @(negedge clk);
    end
    assert (exp_q.size() == 0)
      else report_error($sformatf("%0d expected beats never came out", exp_q.size()));
    repeat (20)
      @(negedge clk);
  endtask

  // Idle outputs while reset is held
  always @(negedge clk)
    if (rst)
      assert (!dct_valid && video_ready)
        else report_error("output valid or input not ready during reset");

  always @(posedge clk)
  begin
    if (rst)
      hold_pending = 1'b0;
    else
    begin
      if (hold_pending)
        assert (dct_valid && (dct_beat == held_beat))
          else report_error("output beat changed while stalled");
      hold_pending = dct_valid && !dct_ready;
      held_beat    = dct_beat;
      if (dct_valid && dct_ready)
      begin
        assert (exp_q.size() != 0)
          else report_error("output beat with no pack outstanding");
        expected = exp_q.pop_front();
        assert (dct_beat.data == expected.data)
          else report_error($sformatf("F%0d data %0d, expected %0d", out_count % 8,
                                      $signed(dct_beat.data), $signed(expected.data)));
        assert ((dct_beat.user == expected.user) && (dct_beat.last == expected.last))
          else report_error($sformatf("F%0d user %b last %b, expected user %b last %b",
                                      out_count % 8, dct_beat.user, dct_beat.last,
                                      expected.user, expected.last));
        got_data[out_count % `DCT_PACK_LEN] = dct_beat.data;
        out_count++;
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES)
      @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "Simulation timeout");
  end

  initial
  begin : main_flow
    logic [PACK_BITS-1:0] pixels;
    int                   stall_cycles;
    seed         = 71943;
    clk          = 1'b0;
    rst          = 1'b1;
    video_beat   = '0;
    video_valid  = 1'b0;
    dct_ready    = 1'b1;
    ready_mode   = READY_HIGH;
    hold_pending = 1'b0;
    out_count    = 0;
    repeat (10)
      @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    assert (!dct_valid && video_ready)
      else report_error("DUT not idle right after reset");
    @(negedge clk);

    // Mid-grey levels shift to zero
    pixels = {`DCT_PACK_LEN{`DCT_PX_WIDTH'(128)}};
    transmit_pack(pixels, 0, -1);
    drain_queue();
    for (int r = 0; r < `DCT_PACK_LEN; r++)
      assert (got_data[r] == 0)
        else report_error($sformatf("F%0d of mid-grey pack is %0d", r, got_data[r]));

    // Flat white leaves only the DC term
    pixels = {`DCT_PACK_LEN{`DCT_PX_WIDTH'(255)}};
    transmit_pack(pixels, -1, -1);
    drain_queue();
    for (int r = 0; r < `DCT_PACK_LEN; r++)
      assert ((r == 0) == (got_data[r] != 0))
        else report_error($sformatf("F%0d of flat white pack is %0d", r, got_data[r]));

    // Row 1 coefficients are all positive, so a rising ramp gives a negative F1
    for (int i = 0; i < `DCT_PACK_LEN; i++)
      pixels[i*`DCT_PX_WIDTH +: `DCT_PX_WIDTH] = `DCT_PX_WIDTH'(i * 32);
    transmit_pack(pixels, -1, `DCT_PACK_LEN - 1);
    drain_queue();
    assert (got_data[1] < 0)
      else report_error($sformatf("F1 of rising ramp is %0d, expected negative", got_data[1]));

    repeat (FAST_PACKS)
      random_pack();
    drain_queue();

    ready_mode = READY_RANDOM;
    repeat (BP_PACKS)
      random_pack();
    drain_queue();

    // Long output stall until the input side gives up
    ready_mode = READY_LOW;
    fork
      repeat (HOLD_PACKS)
        random_pack();
      begin
        stall_cycles = 0;
        @(posedge clk);
        while (video_ready && (stall_cycles < STALL_CYCLES))
        begin
          stall_cycles++;
          @(posedge clk);
        end
        assert (!video_ready)
          else report_error("input ready never fell during output stall");
        repeat (50)
          @(posedge clk);
        ready_mode = READY_HIGH;
      end
    join
    drain_queue();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== dct_1d_top.f ====
+incdir+hw
+incdir+dv
hw/dct_stream_pkg.sv
hw/dct_math_pkg.sv
hw/dct_pack_buffer.sv
hw/dct_butterfly.sv
hw/dct_row_sequencer.sv
hw/dct_mult_lane.sv
hw/dct_output_stage.sv
hw/dct_1d_top.sv
dv/dct_1d_tb.sv
